// ==== rtl/mcu_config.svh ====
`ifndef MCU_CONFIG_SVH
`define MCU_CONFIG_SVH

// Bus and microinstruction field widths
`define MCU_WORD_W      64
`define MCU_YDST_W      4
`define MCU_YDEV_W      3
`define MCU_DDEV_W      3
`define MCU_DSRC_W      4
`define MCU_FFCNT_W     5
`define MCU_MPADR_W     4
`define MCU_COND_W      5

// Memory depths
`define MCU_PAGE_DEPTH  1024          // Page table entries
`define MCU_MP_DEPTH    16            // Exchange memory bytes

// --------------------
// Y-bus destinations (YDST)
`define MCU_YDST_MODGN  4'd1          // Modifier group number
`define MCU_YDST_PROCN  4'd2          // Process number
`define MCU_YDST_RR     4'd3          // Mode register
`define MCU_YDST_PHYSPG 4'd4          // Physical page
`define MCU_YDST_UREG   4'd8          // Effective address register

// Y-bus devices (YDEV)
`define MCU_YDEV_RADRR  3'd3          // UREG readback
`define MCU_YDEV_PSMEM  3'd4          // Page table
`define MCU_YDEV_MPMEM  3'd5          // Exchange memory
`define MCU_YDEV_STOPM0 3'd6          // Stop flag 0
`define MCU_YDEV_STOPM1 3'd7          // Stop flag 1

// D-bus sources and devices
`define MCU_DSRC_MODGN  4'd1
`define MCU_DSRC_PROCN  4'd2
`define MCU_DSRC_RR     4'd3
`define MCU_DSRC_PHYSPG 4'd4
`define MCU_DDEV_CLRCB  3'd3          // Clears the address-change flag

// --------------------
// Flag set/reset decoder (FFCNT with IOMP low)
`define MCU_FF_LOGGRP   5'd1
`define MCU_FF_MULGRP   5'd2
`define MCU_FF_ADDGRP   5'd3
`define MCU_FF_SETC     5'd5
`define MCU_FF_CLRRCB   5'd6
`define MCU_FF_SETRCB   5'd7
`define MCU_FF_CLRJMP   5'd8
`define MCU_FF_SETJMP   5'd9
`define MCU_FF_SETEI    5'd10
`define MCU_FF_CLREI    5'd11
`define MCU_FF_CLRTR0   5'd12
`define MCU_FF_SETTR0   5'd13
`define MCU_FF_CLRTR1   5'd14
`define MCU_FF_SETTR1   5'd15
`define MCU_FF_CLRTKK   5'd18
`define MCU_FF_SETTKK   5'd19
`define MCU_FF_SETNR    5'd20
`define MCU_FF_SETER    5'd22
`define MCU_FF_CHTKK    5'd23

`endif

// ==== rtl/mcu_pkg.sv ====
`include "mcu_config.svh"

package mcu_pkg;

    typedef logic [`MCU_WORD_W-1:0] word_t;     // Y and D bus word
    typedef logic [19:0] page_entry_t;          // Page table entry
    typedef logic [7:0]  mp_byte_t;             // Exchange memory byte

    // Mode register, bit 31 first
    typedef struct packed {
        logic [1:0] unused;         // 31:30
        logic       jump;           // Control transfer flag
        logic       rcb;            // Right command flag
        logic       cb;             // Address change flag
        logic       no_paging;
        logic       no_procnm;
        logic       negaddr;        // Negative address mode
        logic       no_rprot;
        logic       no_wprot;
        logic       intstp;         // Stop on interrupt
        logic       single_step;
        logic       cemlrg;         // Reserve bit 19
        logic       no_wtag;
        logic       no_intr;        // External interrupt mask
        logic       no_progtag;
        logic       no_badacc;
        logic       no_rtag;
        logic       no_badop;
        logic       drg;            // Dispatcher mode
        logic       ovrftb;
        logic       bnb;
        logic       z;              // Status flags Z N C V
        logic       n;
        logic       c;
        logic       v;
        logic       ovrib;
        logic [2:0] grp;            // Branch group
        logic       rndb;           // Rounding block
        logic       normb;          // Normalization block
    } mode_reg_t;

endpackage

// ==== rtl/aux_memory.sv ====
`timescale 1ns/10ps

module aux_memory #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 16
) (
    input  logic                             clk,
    input  logic                             i_we,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] i_waddr,
    input  payload_t                         i_wdata,
    input  logic [$clog2(DEPTH > 1 ? DEPTH : 2)-1:0] i_raddr,
    output payload_t                         o_rdata
);

    payload_t mem [DEPTH];                  // Storage array

    // --------------------
    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;        // Synchronous write
        end
    end

    assign o_rdata = mem[i_raddr];          // Asynchronous read

    // Address must land inside the array
    a_waddr_range: assert property (
        @(posedge clk) i_we |-> (int'(i_waddr) < DEPTH)
    ) else $error("aux_memory write address out of range");

endmodule

// ==== rtl/condition_mux.sv ====
`timescale 1ns/10ps

`include "mcu_config.svh"

module condition_mux (
    input  logic [`MCU_COND_W-1:0] i_cond,     // Condition select
    input  logic                   i_icc,      // High passes, low inverts
    input  mcu_pkg::mode_reg_t     i_rr,       // Mode register
    input  logic                   i_tr0,      // Microprogram flag 0
    input  logic                   i_tr1,      // Microprogram flag 1
    input  logic                   i_tkk,      // Standardizer right command
    input  logic                   i_besm6,    // Emulation mode
    output logic                   o_cond
);

    logic sel;                                  // Selected raw condition

    // --------------------
    always_comb begin
        case (i_cond)
            5'd0:    sel = 1'b1;                // Unconditional yes
            5'd1:    sel = i_rr.normb;          // Normalization block
            5'd2:    sel = i_rr.rndb;           // Rounding block
            5'd3:    sel = i_rr.ovrib;          // Overflow interrupt block
            5'd4:    sel = i_rr.bnb;            // Range check block
            5'd5:    sel = i_rr.ovrftb;
            5'd6:    sel = i_rr.drg;            // Dispatcher mode
            5'd7:    sel = i_besm6;             // Emulation mode
            5'd8:    sel = i_rr.rcb;            // Right command
            5'd9:    sel = i_rr.cb;             // Address changed by reg 16
            5'd10:   sel = i_rr.cemlrg;
            5'd12:   sel = i_tr1;
            5'd13:   sel = i_rr.intstp;         // Stop on interrupt
            5'd14:   sel = 1'b1;                // Stack mode, no decoder here
            5'd15:   sel = i_tkk;
            5'd22:   sel = i_tr0;
            default: sel = 1'b1;                // External conditions read true
        endcase
    end

    // Inversion control
    assign o_cond = i_icc ? sel : ~sel;

endmodule

// ==== rtl/mode_register.sv ====
`timescale 1ns/10ps

`include "mcu_config.svh"

module mode_register (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_accept,    // Transaction strobe
    input  logic [`MCU_YDST_W-1:0]  i_ydst,      // Y destination
    input  mcu_pkg::word_t          i_y,         // Y bus
    input  logic                    i_iomp,      // Low selects flag decoder
    input  logic [`MCU_FFCNT_W-1:0] i_ffcnt,     // Flag operation
    input  logic                    i_ise,       // Interrupt enable strobe
    input  logic [`MCU_DDEV_W-1:0]  i_ddev,      // D device
    output mcu_pkg::mode_reg_t      o_rr,
    output logic                    o_tr0,
    output logic                    o_tr1,
    output logic                    o_tkk,
    output logic                    o_besm6
);

    mcu_pkg::mode_reg_t rr;                      // Mode register
    logic               tr0;                     // Microprogram flag 0
    logic               tr1;                     // Microprogram flag 1
    logic               tkk;                     // Standardizer command toggle
    logic               besm6;                   // Emulation mode
    logic               ff_en;                   // Flag decoder active

    assign ff_en = !i_iomp;

    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            rr    <= '0;
            tr0   <= 1'b0;
            tr1   <= 1'b0;
            tkk   <= 1'b0;
            besm6 <= 1'b0;
        end else if (i_accept) begin
            if (i_ydst == `MCU_YDST_RR) begin
                rr <= mcu_pkg::mode_reg_t'(i_y[31:0]);  // Full load from Y
            end

            // Decoder wins over the Y load for the bit it touches
            if (ff_en) begin
                case (i_ffcnt)
                    `MCU_FF_LOGGRP: rr.grp     <= 3'b001;  // Logic group
                    `MCU_FF_MULGRP: rr.grp     <= 3'b010;  // Multiply group
                    `MCU_FF_ADDGRP: rr.grp     <= 3'b100;  // Add group
                    `MCU_FF_CLRJMP: rr.jump    <= 1'b0;
                    `MCU_FF_SETJMP: rr.jump    <= 1'b1;
                    `MCU_FF_SETEI:  rr.no_intr <= 1'b0;    // Enable interrupts
                    `MCU_FF_CLREI:  rr.no_intr <= 1'b1;    // Mask interrupts
                    `MCU_FF_CLRTR0: tr0        <= 1'b0;
                    `MCU_FF_SETTR0: tr0        <= 1'b1;
                    `MCU_FF_CLRTR1: tr1        <= 1'b0;
                    `MCU_FF_SETTR1: tr1        <= 1'b1;
                    `MCU_FF_CLRTKK: tkk        <= 1'b0;
                    `MCU_FF_SETTKK: tkk        <= 1'b1;
                    `MCU_FF_SETNR:  besm6      <= 1'b0;    // Native mode
                    `MCU_FF_SETER:  besm6      <= 1'b1;    // Emulation mode
                    `MCU_FF_CHTKK:  tkk        <= ~tkk;    // Counting toggle
                    default: ;                             // Handled below or dropped
                endcase
            end

            // Address change flag has its own clear path
            if (i_ddev == `MCU_DDEV_CLRCB) begin
                rr.cb <= 1'b0;
            end else if (ff_en && i_ffcnt == `MCU_FF_SETC) begin
                rr.cb <= 1'b1;
            end

            // Right command flag follows tkk on ISE
            if (i_ise) begin
                rr.rcb <= tkk;                      // Old tkk value
            end else if (ff_en && i_ffcnt == `MCU_FF_CLRRCB) begin
                rr.rcb <= 1'b0;
            end else if (ff_en && i_ffcnt == `MCU_FF_SETRCB) begin
                rr.rcb <= 1'b1;
            end
        end
    end

    assign o_rr    = rr;
    assign o_tr0   = tr0;
    assign o_tr1   = tr1;
    assign o_tkk   = tkk;
    assign o_besm6 = besm6;

    // --------------------
    // Group select must be one-hot after a group load
    a_grp_onehot: assert property (
        @(posedge clk) disable iff (reset)
        (i_accept && ff_en &&
         (i_ffcnt inside {`MCU_FF_LOGGRP, `MCU_FF_MULGRP, `MCU_FF_ADDGRP}))
        |=> $onehot0(rr.grp)
    ) else $error("mode register group not one-hot after flag load");

endmodule

// ==== rtl/bus_registers.sv ====
`timescale 1ns/10ps

`include "mcu_config.svh"

module bus_registers (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_accept,    // Transaction strobe
    input  logic [`MCU_YDST_W-1:0]  i_ydst,      // Y destination
    input  logic [`MCU_YDEV_W-1:0]  i_ydev,      // Y device
    input  logic                    i_wry,       // Write to Y device
    input  logic [`MCU_MPADR_W-1:0] i_mpadr,     // Exchange memory address
    input  logic [`MCU_DSRC_W-1:0]  i_dsrc,      // D source
    input  logic                    i_alu,       // ALU drives Y
    input  mcu_pkg::word_t          i_alu_y,     // ALU result
    input  mcu_pkg::mode_reg_t      i_rr,        // Mode register view
    output mcu_pkg::word_t          o_y,
    output mcu_pkg::word_t          o_d
);

    logic [4:0]           modgn;                 // Modifier group number
    logic [7:0]           procn;                 // Process number
    logic [9:0]           physpg;                // Physical page
    logic [31:0]          ureg;                  // Effective address
    mcu_pkg::page_entry_t ps_rdata;              // Page table read
    mcu_pkg::mp_byte_t    mp_rdata;              // Exchange memory read
    logic                 ps_we;
    logic                 mp_we;

    // --------------------
    // Y bus source select
    always_comb begin
        if (!i_wry && i_ydev == `MCU_YDEV_RADRR) begin
            o_y = mcu_pkg::word_t'(ureg);
        end else if (!i_wry && i_ydev == `MCU_YDEV_PSMEM) begin
            o_y = mcu_pkg::word_t'(ps_rdata);
        end else if (!i_wry && i_ydev == `MCU_YDEV_MPMEM) begin
            o_y = mcu_pkg::word_t'(mp_rdata);
        end else begin
            o_y = i_alu ? i_alu_y : '0;          // ALU or idle bus
        end
    end

    // D bus source select
    always_comb begin
        case (i_dsrc)
            `MCU_DSRC_MODGN:  o_d = mcu_pkg::word_t'({modgn, 5'd0});
            `MCU_DSRC_PROCN:  o_d = mcu_pkg::word_t'(procn);
            `MCU_DSRC_RR:     o_d = mcu_pkg::word_t'(i_rr);
            `MCU_DSRC_PHYSPG: o_d = mcu_pkg::word_t'({physpg, 11'd0});
            default:          o_d = '0;          // Unlisted source
        endcase
    end

    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            modgn  <= '0;
            procn  <= '0;
            physpg <= '0;
            ureg   <= '0;
        end else if (i_accept) begin
            case (i_ydst)
                `MCU_YDST_MODGN:  modgn  <= o_y[9:5];
                `MCU_YDST_PROCN:  procn  <= o_y[7:0];
                `MCU_YDST_PHYSPG: physpg <= o_y[20:11];
                `MCU_YDST_UREG:   ureg   <= o_y[31:0];
                default: ;                       // Mode register lives elsewhere
            endcase
        end
    end

    assign ps_we = i_accept && i_wry && (i_ydev == `MCU_YDEV_PSMEM);
    assign mp_we = i_accept && i_wry && (i_ydev == `MCU_YDEV_MPMEM);

    aux_memory #(
        .payload_t (mcu_pkg::page_entry_t),
        .DEPTH     (`MCU_PAGE_DEPTH)
    ) page_table (
        .clk     (clk),
        .i_we    (ps_we),
        .i_waddr (ureg[19:10]),                  // Virtual page from UREG
        .i_wdata (o_y[19:0]),
        .i_raddr (ureg[19:10]),
        .o_rdata (ps_rdata)
    );

    aux_memory #(
        .payload_t (mcu_pkg::mp_byte_t),
        .DEPTH     (`MCU_MP_DEPTH)
    ) exchange_mem (
        .clk     (clk),
        .i_we    (mp_we),
        .i_waddr (i_mpadr),
        .i_wdata (o_y[7:0]),
        .i_raddr (i_mpadr),
        .o_rdata (mp_rdata)
    );

endmodule

// ==== rtl/mcu_control.sv ====
`timescale 1ns/10ps

`include "mcu_config.svh"

module mcu_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    i_valid,
    output logic                    o_ready,
    input  logic [`MCU_YDST_W-1:0]  i_ydst,
    input  logic [`MCU_YDEV_W-1:0]  i_ydev,
    input  logic                    i_wry,
    input  logic                    i_iomp,
    input  logic [`MCU_FFCNT_W-1:0] i_ffcnt,
    input  logic [`MCU_MPADR_W-1:0] i_mpadr,
    input  logic [`MCU_COND_W-1:0]  i_cond,
    input  logic                    i_icc,
    input  logic                    i_ise,
    input  logic [`MCU_DDEV_W-1:0]  i_ddev,
    input  logic [`MCU_DSRC_W-1:0]  i_dsrc,
    input  logic                    i_alu,
    input  mcu_pkg::word_t          i_alu_y,
    input  logic                    i_ready,
    output logic                    o_valid,
    output mcu_pkg::word_t          o_y,
    output mcu_pkg::word_t          o_d,
    output logic                    o_cond,
    output mcu_pkg::mode_reg_t      o_rr        // Live mode register
);

    logic           accept;                      // Handshake fires
    mcu_pkg::word_t y_bus;
    mcu_pkg::word_t d_bus;
    logic           cond;
    logic           tr0;
    logic           tr1;
    logic           tkk;
    logic           besm6;

    assign o_ready = !o_valid || i_ready;        // Single slot
    assign accept  = i_valid && o_ready;

    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            o_valid <= 1'b0;
        end else if (accept) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;                     // Result taken
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_y    <= '0;
            o_d    <= '0;
            o_cond <= 1'b0;
        end else if (accept) begin
            o_y    <= y_bus;                     // Pre-update state values
            o_d    <= d_bus;
            o_cond <= cond;
        end
    end

    mode_register u_mode (
        .clk(clk), .reset(reset), .i_accept(accept), .i_ydst(i_ydst), .i_y(y_bus),
        .i_iomp(i_iomp), .i_ffcnt(i_ffcnt), .i_ise(i_ise), .i_ddev(i_ddev),
        .o_rr(o_rr), .o_tr0(tr0), .o_tr1(tr1), .o_tkk(tkk), .o_besm6(besm6)
    );

    condition_mux u_cond (
        .i_cond(i_cond), .i_icc(i_icc), .i_rr(o_rr), .i_tr0(tr0), .i_tr1(tr1),
        .i_tkk(tkk), .i_besm6(besm6), .o_cond(cond)
    );

    bus_registers u_bus (
        .clk(clk), .reset(reset), .i_accept(accept), .i_ydst(i_ydst), .i_ydev(i_ydev),
        .i_wry(i_wry), .i_mpadr(i_mpadr), .i_dsrc(i_dsrc), .i_alu(i_alu),
        .i_alu_y(i_alu_y), .i_rr(o_rr), .o_y(y_bus), .o_d(d_bus)
    );

    // Stalled result stays put
    a_result_hold: assert property (
        @(posedge clk) disable iff (reset)
        (o_valid && !i_ready) |=> (o_valid && $stable(o_y) && $stable(o_d) && $stable(o_cond))
    ) else $error("result changed while stalled");

endmodule

// ==== test/mcu_model.svh ====
`ifndef MCU_MODEL_SVH
`define MCU_MODEL_SVH

// --------------------
// Reference state of the control unit
mcu_pkg::mode_reg_t   m_rr;                          // Mode register
logic                 m_tr0;                         // Microprogram flags
logic                 m_tr1;
logic                 m_tkk;                         // Right command toggle
logic                 m_besm6;                       // Emulation mode
logic [4:0]           m_modgn;
logic [7:0]           m_procn;
logic [9:0]           m_physpg;
logic [31:0]          m_ureg;                        // Effective address
mcu_pkg::page_entry_t m_page [`MCU_PAGE_DEPTH];
bit                   m_page_ok [`MCU_PAGE_DEPTH];   // Entry written at least once
mcu_pkg::mp_byte_t    m_mp [`MCU_MP_DEPTH];
bit                   m_mp_ok [`MCU_MP_DEPTH];

// Expected results, oldest first
mcu_pkg::word_t       exp_y_q [$];
mcu_pkg::word_t       exp_d_q [$];
logic                 exp_c_q [$];

task automatic clear_model_state();
    m_rr      = '0;
    m_tr0     = 1'b0;
    m_tr1     = 1'b0;
    m_tkk     = 1'b0;
    m_besm6   = 1'b0;
    m_modgn   = '0;
    m_procn   = '0;
    m_physpg  = '0;
    m_ureg    = '0;
    m_page_ok = '{default: 1'b0};                    // Memories hold no reset value
    m_mp_ok   = '{default: 1'b0};
endtask

// --------------------
// Result rules, all on state before the accepting edge
function automatic mcu_pkg::word_t predict_y();
    if (!i_wry && i_ydev == `MCU_YDEV_RADRR)
        return mcu_pkg::word_t'(m_ureg);
    if (!i_wry && i_ydev == `MCU_YDEV_PSMEM)
        return mcu_pkg::word_t'(m_page[m_ureg[19:10]]);   // Virtual page index
    if (!i_wry && i_ydev == `MCU_YDEV_MPMEM)
        return mcu_pkg::word_t'(m_mp[i_mpadr]);
    return i_alu ? i_alu_y : '0;                     // Idle bus reads zero
endfunction

function automatic mcu_pkg::word_t predict_d();
    case (i_dsrc)
        4'd1:    return mcu_pkg::word_t'(m_modgn) << 5;
        4'd2:    return mcu_pkg::word_t'(m_procn);
        4'd3:    return mcu_pkg::word_t'(m_rr);
        4'd4:    return mcu_pkg::word_t'(m_physpg) << 11;
        default: return '0;
    endcase
endfunction

function automatic logic predict_cond();
    logic [31:0] cv;                                 // Value per condition code
    cv     = '1;                                     // Dropped codes read true
    cv[1]  = m_rr.normb;
    cv[2]  = m_rr.rndb;
    cv[3]  = m_rr.ovrib;
    cv[4]  = m_rr.bnb;
    cv[5]  = m_rr.ovrftb;
    cv[6]  = m_rr.drg;
    cv[7]  = m_besm6;
    cv[8]  = m_rr.rcb;
    cv[9]  = m_rr.cb;
    cv[10] = m_rr.cemlrg;
    cv[12] = m_tr1;
    cv[13] = m_rr.intstp;
    cv[15] = m_tkk;
    cv[22] = m_tr0;
    return i_icc ? cv[i_cond] : !cv[i_cond];         // Low icc inverts
endfunction

// --------------------
// One accepted transaction: queue the result, then move the state
task automatic apply_transaction();
    mcu_pkg::word_t     y;
    mcu_pkg::mode_reg_t rr;
    logic               old_tkk;
    logic [9:0]         page_idx;
    y        = predict_y();
    old_tkk  = m_tkk;
    page_idx = m_ureg[19:10];                        // Page address from old UREG
    exp_y_q.push_back(y);
    exp_d_q.push_back(predict_d());
    exp_c_q.push_back(predict_cond());
    rr = m_rr;
    if (i_ydst == `MCU_YDST_RR)
        rr = mcu_pkg::mode_reg_t'(y[31:0]);
    if (!i_iomp) begin
        case (i_ffcnt)                               // Odd code sets, even clears
            5'd1, 5'd2, 5'd3: rr.grp = 3'b001 << (i_ffcnt - 5'd1);
            5'd8, 5'd9:       rr.jump = i_ffcnt[0];
            5'd10, 5'd11:     rr.no_intr = i_ffcnt[0];
            5'd12, 5'd13:     m_tr0 = i_ffcnt[0];
            5'd14, 5'd15:     m_tr1 = i_ffcnt[0];
            5'd18, 5'd19:     m_tkk = i_ffcnt[0];
            5'd20, 5'd22:     m_besm6 = i_ffcnt[1];
            5'd23:            m_tkk = ~old_tkk;      // Toggle
            default: ;
        endcase
    end
    if (i_ddev == 3'd3)
        rr.cb = 1'b0;                                // D device clear first
    else if (!i_iomp && i_ffcnt == 5'd5)
        rr.cb = 1'b1;
    if (i_ise)
        rr.rcb = old_tkk;
    else if (!i_iomp && (i_ffcnt == 5'd6 || i_ffcnt == 5'd7))
        rr.rcb = i_ffcnt[0];
    m_rr = rr;
    case (i_ydst)
        4'd1: m_modgn  = y[9:5];
        4'd2: m_procn  = y[7:0];
        4'd4: m_physpg = y[20:11];
        4'd8: m_ureg   = y[31:0];
        default: ;
    endcase
    if (i_wry && i_ydev == 3'd4) begin
        m_page[page_idx]    = y[19:0];
        m_page_ok[page_idx] = 1'b1;
    end
    if (i_wry && i_ydev == 3'd5) begin
        m_mp[i_mpadr]    = y[7:0];
        m_mp_ok[i_mpadr] = 1'b1;
    end
endtask

`endif

// ==== test/tb_mcu_control.sv ====
`timescale 1ns/10ps

`include "mcu_config.svh"

module tb_mcu_control;

    localparam int NUM_TESTS    = 5;
    localparam int TXN_PER_TEST = 300;
    localparam int MAX_CYCLES   = NUM_TESTS * TXN_PER_TEST * 12 + 2000;   // 20000

    logic                    clk;
    logic                    reset;
    logic                    i_valid;
    logic                    o_ready;
    logic [`MCU_YDST_W-1:0]  i_ydst;
    logic [`MCU_YDEV_W-1:0]  i_ydev;
    logic                    i_wry;
    logic                    i_iomp;
    logic [`MCU_FFCNT_W-1:0] i_ffcnt;
    logic [`MCU_MPADR_W-1:0] i_mpadr;
    logic [`MCU_COND_W-1:0]  i_cond;
    logic                    i_icc;
    logic                    i_ise;
    logic [`MCU_DDEV_W-1:0]  i_ddev;
    logic [`MCU_DSRC_W-1:0]  i_dsrc;
    logic                    i_alu;
    mcu_pkg::word_t          i_alu_y;
    logic                    i_ready;
    logic                    o_valid;
    mcu_pkg::word_t          o_y;
    mcu_pkg::word_t          o_d;
    logic                    o_cond;
    mcu_pkg::mode_reg_t      o_rr;

    logic [31:0]    rng_state;                       // LCG state
    int             cycle_cnt = 0;
    int             chk_cnt   = 0;
    int             err_cnt   = 0;
    int             txn_cnt   = 0;
    logic           stalled   = 1'b0;                // Result held last edge
    mcu_pkg::word_t held_y;
    mcu_pkg::word_t held_d;
    logic           held_c;

    `include "mcu_model.svh"

    mcu_control dut (
        .clk(clk), .reset(reset), .i_valid(i_valid), .o_ready(o_ready),
        .i_ydst(i_ydst), .i_ydev(i_ydev), .i_wry(i_wry), .i_iomp(i_iomp),
        .i_ffcnt(i_ffcnt), .i_mpadr(i_mpadr), .i_cond(i_cond), .i_icc(i_icc),
        .i_ise(i_ise), .i_ddev(i_ddev), .i_dsrc(i_dsrc), .i_alu(i_alu),
        .i_alu_y(i_alu_y), .i_ready(i_ready), .o_valid(o_valid), .o_y(o_y),
        .o_d(o_d), .o_cond(o_cond), .o_rr(o_rr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                       // 8 ns period
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

    // --------------------
    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return {16'd0, r[31:16]} % n;                // High bits have the longer period
    endfunction

    task automatic report_mismatch(input string name, input mcu_pkg::word_t exp,
                                   input mcu_pkg::word_t got);
        $display("[ERROR] %s expected 0x%h got 0x%h", name, exp, got);
        err_cnt++;
    endtask

    task automatic report_problem(input string msg);
        $display("error: %s", msg);
        err_cnt++;
    endtask

    // Outputs as seen just before the edge
    task automatic check_outputs();
        mcu_pkg::word_t exp_y;
        mcu_pkg::word_t exp_d;
        logic           exp_c;
        logic           exp_v;
        logic           exp_r;
        exp_v = exp_y_q.size() != 0;                 // One item in flight
        exp_r = !exp_v || i_ready;
        chk_cnt += 3;
        assert (o_rr == m_rr) else report_mismatch("o_rr", {32'd0, m_rr}, {32'd0, o_rr});
        assert (o_valid == exp_v) else report_mismatch("o_valid", 64'(exp_v), 64'(o_valid));
        assert (o_ready == exp_r) else report_mismatch("o_ready", 64'(exp_r), 64'(o_ready));
        if (stalled) begin
            chk_cnt++;
            assert (o_valid && o_y == held_y && o_d == held_d && o_cond == held_c)
                else report_problem("result changed or dropped while i_ready was low");
        end
        if (o_valid && i_ready) begin
            chk_cnt++;
            assert (exp_y_q.size() != 0)
                else report_problem("result delivered with no accepted transaction");
            if (exp_y_q.size() != 0) begin
                exp_y = exp_y_q.pop_front();
                exp_d = exp_d_q.pop_front();
                exp_c = exp_c_q.pop_front();
                chk_cnt += 3;
                assert (o_y == exp_y) else report_mismatch("o_y", exp_y, o_y);
                assert (o_d == exp_d) else report_mismatch("o_d", exp_d, o_d);
                assert (o_cond == exp_c) else report_mismatch("o_cond", 64'(exp_c), 64'(o_cond));
            end
        end
        stalled = o_valid && !i_ready;
        held_y  = o_y;
        held_d  = o_d;
        held_c  = o_cond;
    endtask

    // --------------------
    // Random new item biased per test
    task automatic drive_item(input int phase);
        logic [2:0] ydev;
        logic [3:0] mpadr;
        logic       wry;
        ydev    = 3'(rand_below(8));
        mpadr   = 4'(rand_below(16));
        wry     = rand_below(2) == 0;
        i_ydst  <= 4'(rand_below(16));
        i_iomp  <= rand_below(2) == 0;
        i_ffcnt <= 5'(rand_below(24));
        i_cond  <= 5'(rand_below(32));
        i_icc   <= rand_below(2) == 0;
        i_ise   <= rand_below(4) == 0;
        i_ddev  <= 3'(rand_below(8));
        i_dsrc  <= 4'(rand_below(8));
        i_alu   <= rand_below(4) != 0;
        i_alu_y <= {lcg_next(), lcg_next()};
        case (phase)
            2: begin                                 // Register loads read back over D
                i_ydst <= 4'(1 + rand_below(4));
                i_dsrc <= 4'(1 + rand_below(4));
                i_iomp <= 1'b1;
                ydev   = 3'd0;
            end
            3: begin                                 // UREG and both memories
                i_ydst <= rand_below(2) == 0 ? `MCU_YDST_UREG : 4'd0;
                ydev   = 3'(3 + rand_below(3));
            end
            4: begin                                 // Decoder against RR loads
                i_iomp <= 1'b0;
                i_ydst <= rand_below(3) == 0 ? `MCU_YDST_RR : 4'd0;
            end
            5: i_iomp <= 1'b0;                       // Keep flags moving
            default: ;
        endcase
        if (!wry && ydev == `MCU_YDEV_PSMEM && !m_page_ok[m_ureg[19:10]])
            wry = 1'b1;                              // Write before first read
        if (!wry && ydev == `MCU_YDEV_MPMEM && !m_mp_ok[mpadr])
            wry = 1'b1;
        i_ydev  <= ydev;
        i_wry   <= wry;
        i_mpadr <= mpadr;
        i_valid <= 1'b1;
    endtask

    task automatic run_test(input int phase, input string name);
        int issued;
        int chk_start;
        int err_start;
        issued    = 0;
        chk_start = chk_cnt;
        err_start = err_cnt;
        while (issued < TXN_PER_TEST || i_valid || o_valid) begin
            @(posedge clk);
            check_outputs();
            if (i_valid && o_ready) begin
                apply_transaction();
                issued++;
                txn_cnt++;
            end
            if (phase == 1)
                i_ready <= rand_below(2) == 0;       // Half stalled
            else
                i_ready <= rand_below(4) != 0;
            if (!i_valid || o_ready) begin
                if (issued < TXN_PER_TEST && rand_below(4) != 0)
                    drive_item(phase);
                else
                    i_valid <= 1'b0;
            end
        end
        $display("test %0d %s: %0d checks, %0d errors", phase, name,
                 chk_cnt - chk_start, err_cnt - err_start);
    endtask

    // --------------------
    initial begin
        reset   = 1'b1;
        i_valid = 1'b0;
        i_ydst  = '0;
        i_ydev  = '0;
        i_wry   = 1'b0;
        i_iomp  = 1'b1;
        i_ffcnt = '0;
        i_mpadr = '0;
        i_cond  = '0;
        i_icc   = 1'b1;
        i_ise   = 1'b0;
        i_ddev  = '0;
        i_dsrc  = '0;
        i_alu   = 1'b0;
        i_alu_y = '0;
        i_ready = 1'b1;
        rng_state = 32'd53;
        clear_model_state();
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        chk_cnt += 2;
        assert (!o_valid) else report_problem("o_valid high after reset");
        assert (o_ready) else report_problem("o_ready low after reset");
        run_test(1, "handshake");
        run_test(2, "register path");
        run_test(3, "memories");
        run_test(4, "flag decoder");
        run_test(5, "condition");
        chk_cnt++;
        assert (exp_y_q.size() == 0)
            else report_problem("accepted transactions left without a result");
        $display("total: %0d transactions, %0d checks, %0d errors", txn_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+rtl
+incdir+test
rtl/mcu_pkg.sv
rtl/aux_memory.sv
rtl/condition_mux.sv
rtl/mode_register.sv
rtl/bus_registers.sv
rtl/mcu_control.sv
test/tb_mcu_control.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the MCU control testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_mcu_control \
    -f src.f -o sim_mcu_control \
    && ./obj_dir/sim_mcu_control > sim.log 2>&1 \
    || echo "build or simulation returned an error"

cat sim.log 2>/dev/null

grep -q "^Test completed successfully$" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
